// ==== verilog/div_defines.svh ====
// Integer divide configuration
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

////////////////////////////////////////////////////////////
// datapath width
////////////////////////////////////////////////////////////

// operand and result width, 32 or 64
`define XLEN 32

////////////////////////////////////////////////////////////
// count widths
////////////////////////////////////////////////////////////

// leading-zero counts and the iteration count
// one extra bit so that a full XLEN count fits
`define DIVCNTW ($clog2(`XLEN) + 1)

// the preprocessor takes lzcB minus lzcA one bit wider
// so that the top bit of the difference is the sign
// bit DIVCNTW of that difference flags A less than B
// a zero divisor counts as XLEN leading zeros

`endif

// ==== verilog/div_pkg.sv ====
// Integer divide types

package div_pkg;

  ////////////////////////////////////////////////////////////
  // operation encoding
  ////////////////////////////////////////////////////////////

  // bit 0 set means unsigned operands
  // bit 1 set means remainder result
  typedef enum logic [1:0] {
    // signed quotient
    DIV  = 2'b00,
    // unsigned quotient
    DIVU = 2'b01,
    // signed remainder
    REM  = 2'b10,
    // unsigned remainder
    REMU = 2'b11
  } divOpE;

  // the encodings match funct3[1:0] of the RISC-V M extension
  // DIV 100, DIVU 101, REM 110, REMU 111
  // so the decoder can pass those two bits straight through

  // the signed forms negate their magnitudes at the end
  // quotient sign is the xor of both operand signs
  // remainder sign follows the dividend

endpackage

// ==== verilog/lzc.sv ====
// Leading zero counter
`timescale 1ns/1ps
`include "div_defines.svh"

module lzc #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]    num,
  output logic [`DIVCNTW-1:0] zeroCnt
);

  // scan from the lsb upward so the highest set bit wins
  // an all-zero input leaves the count at WIDTH
  always_comb begin
    zeroCnt = (`DIVCNTW)'(WIDTH);
    for (int i = 0; i < WIDTH; i++) begin
      if (num[i]) begin
        zeroCnt = (`DIVCNTW)'(WIDTH - 1 - i);
      end
    end
  end

  // the loop unrolls into a priority chain
  // synthesis folds it into a tree of or and mux stages
  // any WIDTH works, powers of two are not required

  // the count must fit the output
  initial begin
    if (WIDTH >= (1 << `DIVCNTW)) begin
      $error("lzc WIDTH too large for DIVCNTW");
    end
  end

endmodule

// ==== verilog/divPreproc.sv ====
// Integer divide preprocessor
`timescale 1ns/1ps
`include "div_defines.svh"

module divPreproc (
  input  logic                clk,
  input  logic                rstN,
  input  logic                start,
  input  div_pkg::divOpE      op,
  input  logic [`XLEN-1:0]    srcA,
  input  logic [`XLEN-1:0]    srcB,
  output logic                go,
  output logic [`XLEN-1:0]    aAbs,
  output logic [`XLEN-1:0]    dAligned,
  output logic [`DIVCNTW-1:0] iterCount,
  output logic                special,
  output logic                negQuot,
  output logic                negRem,
  output logic                bZero,
  output logic                aLessB,
  output logic [`XLEN-1:0]    srcAHeld,
  output div_pkg::divOpE      opHeld
);

  logic                isSigned;
  logic                aSign;
  logic                bSign;
  logic [`XLEN-1:0]    aMag;
  logic [`XLEN-1:0]    bMag;
  logic                aZeroNow;
  logic                bZeroNow;
  logic [`DIVCNTW-1:0] lzcA;
  logic [`DIVCNTW-1:0] lzcB;
  logic [`DIVCNTW:0]   lzDiff;
  logic                aLessBNow;
  logic [`DIVCNTW-1:0] pShift;

  ////////////////////////////////////////////////////////////
  // signs and magnitudes
  ////////////////////////////////////////////////////////////

  // DIV and REM take signed operands
  assign isSigned = (op == div_pkg::DIV) || (op == div_pkg::REM);

  // sign only counts for the signed forms
  assign aSign = srcA[`XLEN-1] & isSigned;
  assign bSign = srcB[`XLEN-1] & isSigned;

  // two's complement magnitude
  // the signed minimum stays as 2^(XLEN-1), which is still right unsigned
  assign aMag = aSign ? -srcA : srcA;
  assign bMag = bSign ? -srcB : srcB;

  // zero flags straight from the sources
  assign aZeroNow = ~(|srcA);
  assign bZeroNow = ~(|srcB);

  ////////////////////////////////////////////////////////////
  // normalization
  ////////////////////////////////////////////////////////////

  lzc #(.WIDTH(`XLEN)) i_lzcA (
    .num     (aMag),
    .zeroCnt (lzcA)
  );

  lzc #(.WIDTH(`XLEN)) i_lzcB (
    .num     (bMag),
    .zeroCnt (lzcB)
  );

  // one bit wider so the msb is the sign of the difference
  assign lzDiff = {1'b0, lzcB} - {1'b0, lzcA};

  // negative difference: divisor has more significant bits than dividend
  assign aLessBNow = lzDiff[`DIVCNTW];

  // quotient bits beyond the first, also the alignment shift
  assign pShift = aLessBNow ? '0 : lzDiff[`DIVCNTW-1:0];

  ////////////////////////////////////////////////////////////
  // start-registered state
  ////////////////////////////////////////////////////////////

  // go follows an accepted start by one cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      go <= 1'b0;
    end else begin
      go <= start;
    end
  end

  // held for the whole operation
  always_ff @(posedge clk) begin
    if (start) begin
      aAbs      <= aMag;
      // top bit of the aligned divisor lines up with the dividend's
      dAligned  <= bMag << pShift;
      iterCount <= pShift;
      // a zero dividend with nonzero divisor also lands in aLessB
      special   <= bZeroNow | aLessBNow | aZeroNow;
      negQuot   <= aSign ^ bSign;
      negRem    <= aSign;
      bZero     <= bZeroNow;
      aLessB    <= aLessBNow;
      srcAHeld  <= srcA;
      opHeld    <= op;
    end
  end

endmodule

// ==== verilog/divIter.sv ====
// Restoring radix-2 divide iteration
`timescale 1ns/1ps
`include "div_defines.svh"

module divIter (
  input  logic                clk,
  input  logic                rstN,
  input  logic                go,
  input  logic                special,
  input  logic [`XLEN-1:0]    aAbs,
  input  logic [`XLEN-1:0]    dAligned,
  input  logic [`DIVCNTW-1:0] iterCount,
  output logic                busy,
  output logic                iterDone,
  output logic [`XLEN-1:0]    quot,
  output logic [`XLEN-1:0]    rem
);

  logic                running;
  logic                lastStepDone;
  logic [`XLEN-1:0]    divisor;
  logic [`DIVCNTW-1:0] stepCnt;
  logic [`XLEN-1:0]    remCur;
  logic [`XLEN-1:0]    divCur;
  logic [`XLEN-1:0]    quotCur;
  logic [`DIVCNTW-1:0] cntCur;
  logic                geDiv;
  logic                step;

  ////////////////////////////////////////////////////////////
  // current step operands
  ////////////////////////////////////////////////////////////

  // on go the first step works on the fresh operands directly
  // so the load and the first quotient bit share one edge
  assign remCur  = go ? aAbs : rem;
  assign divCur  = go ? dAligned : divisor;
  assign quotCur = go ? '0 : quot;
  assign cntCur  = go ? iterCount : stepCnt;

  // restoring compare
  assign geDiv = (remCur >= divCur);

  // special cases never step
  assign step = (go & ~special) | running;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      running      <= 1'b0;
      lastStepDone <= 1'b0;
    end else begin
      // keep going until the step with count zero
      running      <= step & (cntCur != '0);
      lastStepDone <= step & (cntCur == '0);
    end
  end

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (step) begin
      // subtract only when it fits
      rem     <= geDiv ? (remCur - divCur) : remCur;
      // quotient bit enters at the lsb
      quot    <= {quotCur[`XLEN-2:0], geDiv};
      divisor <= divCur >> 1;
      stepCnt <= cntCur - 1'b1;
    end
  end

  // special path answers in the go cycle, postprocessor needs no quotient
  assign iterDone = lastStepDone | (go & special);

  // covers go, the stepping cycles and the handoff cycle
  assign busy = go | running | lastStepDone;

endmodule

// ==== verilog/divPostproc.sv ====
// Integer divide postprocessor
`timescale 1ns/1ps
`include "div_defines.svh"

module divPostproc (
  input  logic             clk,
  input  logic             rstN,
  input  logic             iterDone,
  input  logic             bZero,
  input  logic             aLessB,
  input  logic             negQuot,
  input  logic             negRem,
  input  div_pkg::divOpE   opHeld,
  input  logic [`XLEN-1:0] srcAHeld,
  input  logic [`XLEN-1:0] quot,
  input  logic [`XLEN-1:0] rem,
  output logic             done,
  output logic [`XLEN-1:0] result
);

  logic             isRem;
  logic [`XLEN-1:0] quotSigned;
  logic [`XLEN-1:0] remSigned;
  logic [`XLEN-1:0] quotFinal;
  logic [`XLEN-1:0] remFinal;

  ////////////////////////////////////////////////////////////
  // sign correction
  ////////////////////////////////////////////////////////////

  // REM and REMU return the remainder
  assign isRem = (opHeld == div_pkg::REM) || (opHeld == div_pkg::REMU);

  // negate magnitudes back to two's complement
  // min / -1 gives 2^(XLEN-1) here, which negates onto itself
  assign quotSigned = negQuot ? -quot : quot;
  assign remSigned  = negRem ? -rem : rem;

  ////////////////////////////////////////////////////////////
  // RISC-V special cases
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (bZero) begin
      // divide by zero: all ones quotient, dividend back
      quotFinal = '1;
      remFinal  = srcAHeld;
    end else if (aLessB) begin
      // also covers a zero dividend
      quotFinal = '0;
      remFinal  = srcAHeld;
    end else begin
      quotFinal = quotSigned;
      remFinal  = remSigned;
    end
  end

  ////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////

  // single-cycle done pulse
  always_ff @(posedge clk) begin
    if (!rstN) begin
      done <= 1'b0;
    end else begin
      done <= iterDone;
    end
  end

  // holds until the next operation finishes
  always_ff @(posedge clk) begin
    if (iterDone) begin
      result <= isRem ? remFinal : quotFinal;
    end
  end

endmodule

// ==== verilog/intDivUnit.sv ====
// Integer divide unit
`timescale 1ns/1ps
`include "div_defines.svh"

module intDivUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             start,
  input  div_pkg::divOpE   op,
  input  logic [`XLEN-1:0] srcA,
  input  logic [`XLEN-1:0] srcB,
  output logic             busy,
  output logic             done,
  output logic [`XLEN-1:0] result
);

  logic                startAcc;
  logic                go;
  logic [`XLEN-1:0]    aAbs;
  logic [`XLEN-1:0]    dAligned;
  logic [`DIVCNTW-1:0] iterCount;
  logic                special;
  logic                negQuot;
  logic                negRem;
  logic                bZero;
  logic                aLessB;
  logic [`XLEN-1:0]    srcAHeld;
  div_pkg::divOpE      opHeld;
  logic                iterDone;
  logic [`XLEN-1:0]    quot;
  logic [`XLEN-1:0]    rem;

  // start counts only when idle
  assign startAcc = start & ~busy;

  divPreproc i_divPreproc (
    .clk, .rstN, .start(startAcc), .op, .srcA, .srcB,
    .go, .aAbs, .dAligned, .iterCount, .special,
    .negQuot, .negRem, .bZero, .aLessB, .srcAHeld, .opHeld
  );

  divIter i_divIter (
    .clk, .rstN, .go, .special, .aAbs, .dAligned, .iterCount,
    .busy, .iterDone, .quot, .rem
  );

  divPostproc i_divPostproc (
    .clk, .rstN, .iterDone, .bZero, .aLessB, .negQuot, .negRem,
    .opHeld, .srcAHeld, .quot, .rem, .done, .result
  );

endmodule

// ==== dv/intDivUnit_assert.sv ====
// Integer divide unit assertions
`timescale 1ns/1ps

module intDivUnit_assert (
  input logic clk,
  input logic rstN,
  input logic start,
  input logic busy,
  input logic done,
  input logic go
);

  // set by an accepted start, cleared by done
  logic armed;
  // failed assertions so far
  int   errCount = 0;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      armed <= 1'b0;
    end else if (start && !busy) begin
      armed <= 1'b1;
    end else if (done) begin
      armed <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////

  // control flops come out of reset idle
  assert property (@(posedge clk) !rstN |=> (!busy && !done))
    else begin
      errCount++;
      $error("busy or done high after reset");
    end

  // done lasts one cycle
  assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else begin
      errCount++;
      $error("done longer than one cycle");
    end

  // every done belongs to an accepted start
  assert property (@(posedge clk) disable iff (!rstN) done |-> armed)
    else begin
      errCount++;
      $error("done without a start");
    end

  // a start while busy never launches, so result is untouched
  assert property (@(posedge clk) disable iff (!rstN) (start && busy) |=> !go)
    else begin
      errCount++;
      $error("start accepted while busy");
    end

endmodule

bind intDivUnit intDivUnit_assert i_intDivUnit_assert (
  .clk, .rstN, .start, .busy, .done, .go
);

// ==== dv/intDivUnit_tb.sv ====
// Integer divide unit testbench
`timescale 1ns/1ps
`include "div_defines.svh"

module intDivUnit_tb;

  logic             clk;
  logic             rstN;
  logic             start;
  div_pkg::divOpE   op;
  logic [`XLEN-1:0] srcA;
  logic [`XLEN-1:0] srcB;
  logic             busy;
  logic             done;
  logic [`XLEN-1:0] result;

  logic [31:0]      lfsrState;

  intDivUnit i_intDivUnit (
    .clk, .rstN, .start, .op, .srcA, .srcB, .busy, .done, .result
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic failRun(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns %s got %0h expected %0h", $time, name, got, exp);
      failRun("value mismatch");
    end
  endtask

  // bound checker assertion failures
  always @(i_intDivUnit.i_intDivUnit_assert.errCount) begin
    if (i_intDivUnit.i_intDivUnit_assert.errCount != 0) begin
      failRun("an assertion in the bound checker failed");
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // RISC-V M extension semantics, SV division truncates toward zero
  function automatic logic [`XLEN-1:0] refResult(input div_pkg::divOpE o,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] minVal;
    logic             ovf;
    minVal = {1'b1, {(`XLEN-1){1'b0}}};
    ovf    = (a == minVal) && (b == '1);
    case (o)
      div_pkg::DIVU: return (b == '0) ? '1 : a / b;
      div_pkg::REMU: return (b == '0) ? a : a % b;
      div_pkg::DIV: begin
        if (b == '0) return '1;
        if (ovf) return minVal;
        return $signed(a) / $signed(b);
      end
      default: begin
        if (b == '0) return a;
        if (ovf) return '0;
        return $signed(a) % $signed(b);
      end
    endcase
  endfunction

  // leading zeros from the top, XLEN for zero
  function automatic int leadZeros(input logic [`XLEN-1:0] v);
    int n;
    bit found;
    n = 0;
    found = 1'b0;
    for (int i = `XLEN - 1; i >= 0; i--) begin
      if (v[i]) found = 1'b1;
      if (!found) n++;
    end
    return n;
  endfunction

  // start to done in cycles: 2 for the fast paths, else p+3
  function automatic int expLatency(input div_pkg::divOpE o,
                                    input logic [`XLEN-1:0] a,
                                    input logic [`XLEN-1:0] b);
    logic             sgn;
    logic [`XLEN-1:0] aM;
    logic [`XLEN-1:0] bM;
    int               la;
    int               lb;
    sgn = (o == div_pkg::DIV) || (o == div_pkg::REM);
    aM  = (sgn && a[`XLEN-1]) ? -a : a;
    bM  = (sgn && b[`XLEN-1]) ? -b : b;
    la  = leadZeros(aM);
    lb  = leadZeros(bM);
    if ((b == '0) || (lb < la)) return 2;
    return lb - la + 3;
  endfunction

  ////////////////////////////////////////////////////////////
  // random source
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic nextBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [`XLEN-1:0] randBits(input int n);
    logic [`XLEN-1:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[`XLEN-2:0], nextBit()};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // one operation
  ////////////////////////////////////////////////////////////

  // entered and left 2 ns after a rising edge
  task automatic doOp(input div_pkg::divOpE o, input logic [`XLEN-1:0] a,
                      input logic [`XLEN-1:0] b, input bit injectBusy);
    logic [`XLEN-1:0] expRes;
    int               expLat;
    int               cycles;
    expRes = refResult(o, a, b);
    expLat = expLatency(o, a, b);
    op     = o;
    srcA   = a;
    srcB   = b;
    start  = 1'b1;
    @(posedge clk);
    #2;
    start  = 1'b0;
    cycles = 1;
    checkVal("busy", busy, 1'b1);
    // a second start with other operands, must be dropped
    if (injectBusy) begin
      start = 1'b1;
      op    = div_pkg::divOpE'(~o);
      srcA  = ~a;
      srcB  = a;
    end
    while (!done) begin
      if (cycles > `XLEN + 10) failRun("timeout while waiting for done");
      @(posedge clk);
      #2;
      start = 1'b0;
      cycles++;
    end
    checkVal("result", result, expRes);
    checkVal("latency", cycles, expLat);
    // busy already low in the done cycle
    checkVal("busy", busy, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic testUnsigned();
    doOp(div_pkg::DIVU, 100, 7, 0);
    doOp(div_pkg::REMU, 100, 7, 0);
    doOp(div_pkg::DIVU, {1'b1, {(`XLEN-1){1'b0}}}, 16, 0);
    doOp(div_pkg::REMU, 1024, 1024, 0);
    doOp(div_pkg::DIVU, 1024, 1, 0);
    doOp(div_pkg::DIVU, '1, 3, 0);
    doOp(div_pkg::REMU, '1, 10, 0);
    doOp(div_pkg::DIVU, '1, 1, 0);
  endtask

  // remainder follows the dividend sign
  task automatic testSigned();
    doOp(div_pkg::DIV, 20, 6, 0);
    doOp(div_pkg::DIV, -20, 6, 0);
    doOp(div_pkg::DIV, 20, -6, 0);
    doOp(div_pkg::DIV, -20, -6, 0);
    doOp(div_pkg::REM, 20, 6, 0);
    doOp(div_pkg::REM, -20, 6, 0);
    doOp(div_pkg::REM, 20, -6, 0);
    doOp(div_pkg::REM, -20, -6, 0);
  endtask

  task automatic testDivZero();
    doOp(div_pkg::DIV, 1234, 0, 0);
    doOp(div_pkg::DIVU, 1234, 0, 0);
    doOp(div_pkg::REM, -77, 0, 0);
    doOp(div_pkg::REMU, '1, 0, 0);
  endtask

  task automatic testFastPath();
    doOp(div_pkg::DIVU, 3, 1000, 0);
    doOp(div_pkg::REMU, 3, 1000, 0);
    doOp(div_pkg::REM, -3, 1000, 0);
    doOp(div_pkg::DIV, 0, 5, 0);
    doOp(div_pkg::REMU, 0, 5, 0);
  endtask

  task automatic testOverflow();
    doOp(div_pkg::DIV, {1'b1, {(`XLEN-1){1'b0}}}, '1, 0);
    doOp(div_pkg::REM, {1'b1, {(`XLEN-1){1'b0}}}, '1, 0);
  endtask

  // divisor shifted right by a random amount to spread the step count
  task automatic testRandom();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    div_pkg::divOpE   o;
    for (int n = 0; n < 200; n++) begin
      a = randBits(`XLEN);
      b = randBits(`XLEN) >> randBits($clog2(`XLEN));
      o = div_pkg::divOpE'(randBits(2));
      doOp(o, a, b, (n % 4) == 0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rstN      = 1'b0;
    start     = 1'b0;
    op        = div_pkg::DIV;
    srcA      = '0;
    srcB      = '0;
    lfsrState = 32'h7b52_0b19;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    testUnsigned();
    testSigned();
    testDivZero();
    testFastPath();
    testOverflow();
    testRandom();
    $display("test passed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/div_pkg.sv
verilog/lzc.sv
verilog/divPreproc.sv
verilog/divIter.sv
verilog/divPostproc.sv
verilog/intDivUnit.sv
dv/intDivUnit_assert.sv
dv/intDivUnit_tb.sv

// ==== Bender.yml ====
package:
  name: int_div_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/div_pkg.sv
      - verilog/lzc.sv
      - verilog/divPreproc.sv
      - verilog/divIter.sv
      - verilog/divPostproc.sv
      - verilog/intDivUnit.sv

  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/intDivUnit_assert.sv
      - dv/intDivUnit_tb.sv
